// File: rtl/skyking_pkg.sv
// Sky King shared constants
`default_nettype none

package skyking_pkg;

	// Pixel coordinates
	localparam int COORD_W = 10;

	// 640x480 horizontal timing in pixel clocks
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT = 16;
	localparam int H_SYNC = 96;
	localparam int H_BACK = 48;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	// Vertical timing in lines
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT = 10;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 33;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// Per-channel colour depth
	localparam int COLOR_W = 2;

	// Scope XY generator
	localparam int XY_X_W = 8;
	localparam int XY_Y_W = 7;
	localparam int XY_STEPS = 32;
	localparam int PHASE_W = 5;
	localparam int TRIG_BIT = 3;

	// Output mode select from ui_in
	localparam int MODE_W = 2;

endpackage

`default_nettype wire

// File: rtl/vga_sync_gen.sv
// VGA sync generator
`timescale 1ns/1ps
`default_nettype none

module vga_sync_gen
	import skyking_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	output logic [COORD_W-1:0] hpos,
	output logic [COORD_W-1:0] vpos,
	output logic               hsync,
	output logic               vsync,
	output logic               display_on
);

	logic h_wrap;
	logic v_wrap;

	assign h_wrap = (hpos == COORD_W'(H_TOTAL - 1));
	assign v_wrap = (vpos == COORD_W'(V_TOTAL - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hpos <= '0;
		end else if (h_wrap) begin
			hpos <= '0;
		end else begin
			hpos <= hpos + 1'b1;
		end
	end

	// Line counter advances once per line
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vpos <= '0;
		end else if (h_wrap) begin
			if (v_wrap) begin
				vpos <= '0;
			end else begin
				vpos <= vpos + 1'b1;
			end
		end
	end

	// Both syncs are active low
	assign hsync = !((hpos >= H_ACTIVE + H_FRONT) && (hpos < H_ACTIVE + H_FRONT + H_SYNC));
	assign vsync = !((vpos >= V_ACTIVE + V_FRONT) && (vpos < V_ACTIVE + V_FRONT + V_SYNC));

	assign display_on = (hpos < H_ACTIVE) && (vpos < V_ACTIVE);

endmodule

`default_nettype wire

// File: rtl/scene_renderer.sv
// Sky and aircraft renderer
`timescale 1ns/1ps
`default_nettype none

module scene_renderer
	import skyking_pkg::*;
(
	input  logic [COORD_W-1:0] hpos,
	input  logic [COORD_W-1:0] vpos,
	input  logic               display_on,
	output logic [COLOR_W-1:0] r,
	output logic [COLOR_W-1:0] g,
	output logic [COLOR_W-1:0] b
);

	logic [1:0]         band;
	logic [COLOR_W-1:0] r_sky;
	logic [COLOR_W-1:0] g_sky;
	logic               plane;
	logic               lit;

	// Inclusive bounds on both axes
	function automatic logic in_rect(input int x, input int y,
			input int x0, input int x1, input int y0, input int y1);
		return (x >= x0) && (x <= x1) && (y >= y0) && (y <= y1);
	endfunction

	// Four horizontal bands, warmer toward the bottom
	assign band = vpos[8:7];
	assign r_sky = {1'b1, ~&band};
	assign g_sky = ~band;

	assign plane = in_rect(hpos, vpos, 310, 330, 180, 300)
		| in_rect(hpos, vpos, 260, 380, 230, 240)
		| in_rect(hpos, vpos, 270, 370, 240, 244)
		| in_rect(hpos, vpos, 290, 350, 295, 300)
		| in_rect(hpos, vpos, 300, 340, 293, 295)
		| in_rect(hpos, vpos, 287, 293, 210, 255)
		| in_rect(hpos, vpos, 347, 353, 210, 255)
		| in_rect(hpos, vpos, 280, 300, 215, 216)
		| in_rect(hpos, vpos, 340, 360, 215, 216)
		| in_rect(hpos, vpos, 315, 325, 175, 180);

	// Silhouette and blanking both force black
	assign lit = display_on && !plane;

	assign r = lit ? r_sky : '0;
	assign g = lit ? g_sky : '0;
	assign b = '0;

endmodule

`default_nettype wire

// File: rtl/xy_pattern_gen.sv
// Scope XY pattern generator
`timescale 1ns/1ps
`default_nettype none

module xy_pattern_gen
	import skyking_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	output logic [XY_X_W-1:0] x_out,
	output logic [XY_Y_W-1:0] y_out,
	output logic              trig
);

	// One lap of the closed figure, phase 0 first
	localparam logic [XY_X_W-1:0] X_TABLE [XY_STEPS] = '{
		8'd186, 8'd207, 8'd225, 8'd239, 8'd249, 8'd254, 8'd254, 8'd249,
		8'd240, 8'd226, 8'd209, 8'd188, 8'd165, 8'd140, 8'd115, 8'd91,
		8'd68,  8'd47,  8'd29,  8'd15,  8'd5,   8'd0,   8'd0,   8'd5,
		8'd14,  8'd28,  8'd46,  8'd67,  8'd90,  8'd114, 8'd139, 8'd164
	};

	localparam logic [XY_Y_W-1:0] Y_TABLE [XY_STEPS] = '{
		7'd120, 7'd113, 7'd104, 7'd94,  7'd83,  7'd71,  7'd58,  7'd46,
		7'd34,  7'd24,  7'd15,  7'd7,   7'd3,   7'd0,   7'd0,   7'd2,
		7'd7,   7'd13,  7'd22,  7'd33,  7'd44,  7'd56,  7'd69,  7'd81,
		7'd93,  7'd103, 7'd112, 7'd119, 7'd124, 7'd126, 7'd126, 7'd124
	};

	logic [PHASE_W-1:0] phase;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= '0;
		end else if (phase == PHASE_W'(XY_STEPS - 1)) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// Sample registers load the entry of the phase before it steps
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			x_out <= '0;
			y_out <= '0;
		end else begin
			x_out <= X_TABLE[phase];
			y_out <= Y_TABLE[phase];
		end
	end

	// Runs one entry ahead of the registered sample
	assign trig = phase[TRIG_BIT];

endmodule

`default_nettype wire

// File: rtl/pin_mux.sv
// Output pin multiplexer
`timescale 1ns/1ps
`default_nettype none

module pin_mux
	import skyking_pkg::*;
(
	input  logic [MODE_W-1:0]  mode,
	input  logic               hsync,
	input  logic               vsync,
	input  logic [COLOR_W-1:0] r,
	input  logic [COLOR_W-1:0] g,
	input  logic [COLOR_W-1:0] b,
	input  logic [XY_X_W-1:0]  x_out,
	input  logic [XY_Y_W-1:0]  y_out,
	input  logic               trig,
	output logic [7:0]         uo_out,
	output logic [7:0]         uio_out
);

	logic [7:0] vga_byte;
	logic [7:0] scope1_byte;
	logic [7:0] scope2_y_byte;
	logic [7:0] scope2_x_byte;

	// TinyVGA PMOD pinout
	assign vga_byte = {hsync, b[0], g[0], r[0], vsync, b[1], g[1], r[1]};

	// Single PMOD carries the upper bits of both axes
	assign scope1_byte = {x_out[4], x_out[6], y_out[4], y_out[6],
		x_out[5], x_out[7], y_out[5], trig};

	// Two PMODs give each axis its own byte
	assign scope2_y_byte = {trig, y_out[5], y_out[3], y_out[1],
		y_out[6], y_out[4], y_out[2], y_out[0]};
	assign scope2_x_byte = {x_out[7], x_out[5], x_out[3], x_out[1],
		x_out[6], x_out[4], x_out[2], x_out[0]};

	// Bit 0 steers uo_out, bit 1 steers uio_out
	assign uo_out = mode[0] ? (mode[1] ? scope2_y_byte : scope1_byte) : vga_byte;
	assign uio_out = mode[1] ? scope2_x_byte : 8'h00;

endmodule

`default_nettype wire

// File: rtl/skyking_top.sv
// Sky King tile top
`timescale 1ns/1ps
`default_nettype none

module skyking_top
	import skyking_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ena,
	input  logic [7:0] ui_in,
	input  logic [7:0] uio_in,
	output logic [7:0] uo_out,
	output logic [7:0] uio_out,
	output logic [7:0] uio_oe
);

	logic [COORD_W-1:0] hpos;
	logic [COORD_W-1:0] vpos;
	logic               hsync;
	logic               vsync;
	logic               display_on;
	logic [COLOR_W-1:0] r;
	logic [COLOR_W-1:0] g;
	logic [COLOR_W-1:0] b;
	logic [XY_X_W-1:0]  x_out;
	logic [XY_Y_W-1:0]  y_out;
	logic               trig;
	logic               unused;

	vga_sync_gen sync_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.hpos       (hpos),
		.vpos       (vpos),
		.hsync      (hsync),
		.vsync      (vsync),
		.display_on (display_on)
	);

	scene_renderer scene_i (
		.hpos       (hpos),
		.vpos       (vpos),
		.display_on (display_on),
		.r          (r),
		.g          (g),
		.b          (b)
	);

	xy_pattern_gen xy_i (
		.clk   (clk),
		.rst_n (rst_n),
		.x_out (x_out),
		.y_out (y_out),
		.trig  (trig)
	);

	pin_mux mux_i (
		.mode    (ui_in[MODE_W-1:0]),
		.hsync   (hsync),
		.vsync   (vsync),
		.r       (r),
		.g       (g),
		.b       (b),
		.x_out   (x_out),
		.y_out   (y_out),
		.trig    (trig),
		.uo_out  (uo_out),
		.uio_out (uio_out)
	);

	// Bidirectional pins are outputs only
	assign uio_oe = 8'hff;

	assign unused = &{ena, ui_in[7:MODE_W], uio_in};

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// Testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

endmodule

`default_nettype wire

// File: tb/skyking_model.svh
// Scene, XY and pin reference model
`ifndef SKYKING_MODEL_SVH
`define SKYKING_MODEL_SVH

logic [7:0] x_ref [32];
logic [6:0] y_ref [32];
// Aircraft parts as x0, x1, y0, y1
int part_box [40];

task automatic load_model_tables();
	x_ref = '{186, 207, 225, 239, 249, 254, 254, 249, 240, 226, 209, 188, 165, 140, 115, 91,
		68, 47, 29, 15, 5, 0, 0, 5, 14, 28, 46, 67, 90, 114, 139, 164};
	y_ref = '{120, 113, 104, 94, 83, 71, 58, 46, 34, 24, 15, 7, 3, 0, 0, 2,
		7, 13, 22, 33, 44, 56, 69, 81, 93, 103, 112, 119, 124, 126, 126, 124};
	part_box = '{
		310, 330, 180, 300,
		260, 380, 230, 240,
		270, 370, 240, 244,
		290, 350, 295, 300,
		300, 340, 293, 295,
		287, 293, 210, 255,
		347, 353, 210, 255,
		280, 300, 215, 216,
		340, 360, 215, 216,
		315, 325, 175, 180
	};
endtask

// Colour as {r1, r0, g1, g0, b1, b0}
function automatic logic [5:0] scene_rgb(input int h, input int v);
	int band;
	int k;
	if (h >= 640 || v >= 480) begin
		return 6'b0;
	end
	for (k = 0; k < 10; k++) begin
		if (h >= part_box[4*k] && h <= part_box[4*k+1]
				&& v >= part_box[4*k+2] && v <= part_box[4*k+3]) begin
			return 6'b0;
		end
	end
	band = (v >> 7) & 3;
	return {1'b1, band != 3, band < 2, (band % 2) == 0, 2'b00};
endfunction

function automatic logic hsync_ref(input int h);
	return !(h >= 656 && h <= 751);
endfunction

function automatic logic vsync_ref(input int v);
	return !(v >= 490 && v <= 491);
endfunction

function automatic logic [7:0] vga_pack(input logic hs, input logic vs, input logic [5:0] c);
	return {hs, c[0], c[2], c[4], vs, c[1], c[3], c[5]};
endfunction

`endif

// File: tb/skyking_tb.sv
// Sky King testbench
`timescale 1ns/1ps
`default_nettype none

module skyking_tb
	import skyking_pkg::*;
();

	localparam int SEED = 92080;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int FIXED_CYCLES = 256;
	localparam int RANDOM_CYCLES = 40000;
	// Two frames plus margin for the shorter phases
	localparam int CYCLE_LIMIT = 2 * FRAME_CYCLES + 160000;

	logic       clk;
	logic       rst_n;
	logic       ena;
	logic [7:0] ui_in;
	logic [7:0] uio_in;
	logic [7:0] uo_out;
	logic [7:0] uio_out;
	logic [7:0] uio_oe;

	int         m_h;
	int         m_v;
	int         m_phase;
	logic [7:0] m_x;
	logic [6:0] m_y;
	int         cycle_count;

	`include "skyking_model.svh"

	tb_clock_gen clk_i (.clk(clk));

	skyking_top dut_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.ena     (ena),
		.ui_in   (ui_in),
		.uio_in  (uio_in),
		.uo_out  (uo_out),
		.uio_out (uio_out),
		.uio_oe  (uio_oe)
	);

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("test failed");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// Follows the counter rules on each rising edge
	task automatic model_step();
		if (!rst_n) begin
			m_h = 0;
			m_v = 0;
			m_phase = 0;
			m_x = '0;
			m_y = '0;
		end else begin
			m_x = x_ref[m_phase];
			m_y = y_ref[m_phase];
			m_phase = (m_phase + 1) % XY_STEPS;
			if (m_h == H_TOTAL - 1) begin
				m_h = 0;
				m_v = (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
			end else begin
				m_h = m_h + 1;
			end
		end
	endtask

	task automatic check_pins();
		logic [5:0] rgb;
		logic [7:0] vga;
		logic       trig;
		logic [7:0] exp_uo;
		logic [7:0] exp_uio;
		rgb = scene_rgb(m_h, m_v);
		vga = vga_pack(hsync_ref(m_h), vsync_ref(m_v), rgb);
		trig = (m_phase >> 3) & 1;
		check_value("hpos", dut_i.sync_i.hpos, m_h);
		check_value("vpos", dut_i.sync_i.vpos, m_v);
		check_value("phase", dut_i.xy_i.phase, m_phase);
		case (ui_in[1:0])
			2'b00: begin
				exp_uo = vga;
				exp_uio = 8'h00;
			end
			2'b01: begin
				exp_uo = {m_x[4], m_x[6], m_y[4], m_y[6], m_x[5], m_x[7], m_y[5], trig};
				exp_uio = 8'h00;
			end
			2'b11: begin
				exp_uo = {trig, m_y[5], m_y[3], m_y[1], m_y[6], m_y[4], m_y[2], m_y[0]};
				exp_uio = {m_x[7], m_x[5], m_x[3], m_x[1], m_x[6], m_x[4], m_x[2], m_x[0]};
			end
			default: begin
				exp_uo = vga;
				exp_uio = {m_x[7], m_x[5], m_x[3], m_x[1], m_x[6], m_x[4], m_x[2], m_x[0]};
			end
		endcase
		if (!ui_in[0]) begin
			check_value("hsync", uo_out[7], hsync_ref(m_h));
			check_value("vsync", uo_out[3], vsync_ref(m_v));
			check_value("colour", {uo_out[0], uo_out[4], uo_out[1], uo_out[5],
				uo_out[2], uo_out[6]}, rgb);
		end
		check_value("uo_out", uo_out, exp_uo);
		check_value("uio_out", uio_out, exp_uio);
		check_value("uio_oe", uio_oe, 8'hff);
	endtask

	// Model steps at the rising edge and pins are checked at the falling edge
	task automatic tick(input logic [1:0] mode, input logic rst_next);
		@(posedge clk);
		model_step();
		@(negedge clk);
		check_pins();
		ui_in[1:0] = mode;
		rst_n = rst_next;
	endtask

	initial begin
		int          i;
		int          hold;
		int          reset_at;
		int          reset_len;
		logic [1:0]  mode;
		void'($urandom(SEED));
		load_model_tables();
		rst_n = 1'b0;
		ena = 1'b1;
		ui_in = 8'h00;
		uio_in = 8'h00;
		m_h = 0;
		m_v = 0;
		m_phase = 0;
		m_x = '0;
		m_y = '0;
		cycle_count = 0;

		tick(2'b00, 1'b0);
		tick(2'b00, 1'b0);
		tick(2'b00, 1'b1);

		for (i = 0; i < 2 * FRAME_CYCLES; i++) begin
			tick(2'b00, 1'b1);
		end
		for (i = 0; i < 3 * FIXED_CYCLES; i++) begin
			mode = (i < FIXED_CYCLES) ? 2'b11 : (i < 2 * FIXED_CYCLES) ? 2'b01 : 2'b10;
			tick(mode, 1'b1);
		end

		// Random modes with one reset somewhere in the middle
		reset_at = $urandom_range(RANDOM_CYCLES - 1000, 1000);
		reset_len = $urandom_range(3, 1);
		hold = 0;
		mode = 2'b00;
		for (i = 0; i < RANDOM_CYCLES; i++) begin
			if (hold == 0) begin
				mode = $urandom_range(3, 0);
				hold = $urandom_range(64, 1);
			end
			hold = hold - 1;
			tick(mode, !(i >= reset_at && i < reset_at + reset_len));
		end

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+tb
rtl/skyking_pkg.sv
rtl/vga_sync_gen.sv
rtl/scene_renderer.sv
rtl/xy_pattern_gen.sv
rtl/pin_mux.sv
rtl/skyking_top.sv
tb/tb_clock_gen.sv
tb/skyking_tb.sv

// File: Bender.yml
package:
  name: skyking

sources:
  - files:
      - rtl/skyking_pkg.sv
      - rtl/vga_sync_gen.sv
      - rtl/scene_renderer.sv
      - rtl/xy_pattern_gen.sv
      - rtl/pin_mux.sv
      - rtl/skyking_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_clock_gen.sv
      - tb/skyking_tb.sv
